/* files.f */
+incdir+src
src/videoPkg.sv
src/crtcAddress.sv
src/charBuffer.sv
src/videoUla.sv
src/displayControl.sv
verification/displayControlTb.sv

/* run.sh */
#!/bin/sh
# Build and run the display subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module displayControlTb --Mdir obj_dir -o displayControlTb -f files.f
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/displayControlTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
	exit 1
fi
exit 0

/* verification/displayControlTb.sv */
`timescale 1ns/1ps
`include "videoDefs_defs.svh"

module displayControlTb;

	import videoPkg::*;

	localparam int LineCycles = `CHAR_PIXELS * `H_TOTAL_CHARS;
	localparam int FrameCycles = LineCycles * `V_TOTAL_LINES;
	localparam int WaitLimit = 2 * FrameCycles;

	logic PIXELCLK;
	logic nRESET;
	regWrite cpuWrite;
	charData vData;
	frameAdr framestoreAdr;
	colour rgb;
	logic hSync;
	logic vSync;

	integer seed;

	// Register values the reference model works from
	int horzDisplay;
	int vertDisplay;
	int maxScanline;
	int cursorStart;
	int cursorEnd;
	int startAdr;
	int cursorAdr;
	logic [7:0] ctrl;
	paletteEntry palette [16];

	displayControl uut (
		.PIXELCLK(PIXELCLK),
		.nRESET(nRESET),
		.cpuWrite(cpuWrite),
		.vData(vData),
		.framestoreAdr(framestoreAdr),
		.rgb(rgb),
		.hSync(hSync),
		.vSync(vSync)
	);

	// Framestore with asynchronous read
	assign vData = framestoreAdr[7:0] ^ 8'h5a;

	initial begin
		PIXELCLK = 1'b0;
		forever #50 PIXELCLK = ~PIXELCLK;
	end

	task automatic failRun(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic reportMismatch(input string name, input int expected, input int actual);
		failRun($sformatf("[ERROR] %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	function automatic int randRange(input int lo, input int hi);
		int r;
		r = $random(seed);
		r = r & 32'h7fffffff;
		return lo + r % (hi - lo + 1);
	endfunction

	task automatic writeBus(input logic ula, input logic a0, input logic [7:0] data);
		@(posedge PIXELCLK);
		#10;
		cpuWrite = {1'b1, ula, a0, data};
	endtask

	task automatic idleBus();
		@(posedge PIXELCLK);
		#10;
		cpuWrite = '0;
	endtask

	// Register number first, then its value
	task automatic writeCrtc(input int regNum, input int value);
		writeBus(1'b0, 1'b0, 8'(regNum));
		writeBus(1'b0, 1'b1, 8'(value));
	endtask

	task automatic programRegisters(input int frame);
		int rowLimit;
		int row;
		int col;
		horzDisplay = randRange(1, 12);
		vertDisplay = randRange(1, 8);
		maxScanline = randRange(0, 9);
		cursorStart = randRange(0, 9);
		cursorEnd = randRange(cursorStart, 9);
		startAdr = randRange(0, 16383);
		// Cursor mostly lands on a character that is shown
		rowLimit = vertDisplay;
		if (rowLimit * (maxScanline + 1) > `V_SYNC_START)
			rowLimit = `V_SYNC_START / (maxScanline + 1);
		row = randRange(0, rowLimit - 1);
		col = randRange(0, horzDisplay - 1);
		if (randRange(0, 3) == 0)
			cursorAdr = randRange(0, 16383);
		else
			cursorAdr = (startAdr + row * horzDisplay + col) % 16384;
		// Each frame gets its own cursor and flash combination
		ctrl = 8'(randRange(0, 255));
		ctrl[7] = frame[1];
		ctrl[0] = frame[0];
		for (int i = 0; i < 16; i++)
			palette[i] = 4'(randRange(0, 15));

		writeCrtc(1, horzDisplay);
		writeCrtc(6, vertDisplay);
		writeCrtc(9, maxScanline);
		writeCrtc(10, cursorStart);
		writeCrtc(11, cursorEnd);
		writeCrtc(12, startAdr >> 8);
		writeCrtc(13, startAdr & 255);
		writeCrtc(14, cursorAdr >> 8);
		writeCrtc(15, cursorAdr & 255);
		writeBus(1'b1, 1'b0, ctrl);
		for (int i = 0; i < 16; i++)
			writeBus(1'b1, 1'b1, {4'(i), palette[i]});
		idleBus();
	endtask

	// Framestore address of one slot of the displayed frame
	function automatic int slotAddress(input int line, input int slot);
		int row;
		row = line / (maxScanline + 1);
		return (startAdr + row * horzDisplay + slot) % 16384;
	endfunction

	// Reference colour of one pixel of the displayed frame
	function automatic colour expectedPixel(input int line, input int slot, input int pix);
		int row;
		int rowAddress;
		int adr;
		logic shown;
		logic onCursor;
		charData shiftReg;
		paletteEntry entry;
		colour c;
		row = line / (maxScanline + 1);
		rowAddress = line % (maxScanline + 1);
		adr = slotAddress(line, slot);
		shown = slot < horzDisplay && row < vertDisplay && line < `V_SYNC_START;
		onCursor = adr == cursorAdr && rowAddress >= cursorStart
			&& rowAddress <= cursorEnd && shown;
		shiftReg = charData'(adr) ^ 8'h5a;
		// Pixels leave from the top, ones come in at the bottom
		for (int k = 0; k < pix; k++)
			shiftReg = {shiftReg[6:0], 1'b1};
		entry = palette[{shiftReg[7], shiftReg[5], shiftReg[3], shiftReg[1]}];
		c = 3'b000;
		if (shown && rowAddress < 8)
			c = entry[2:0] ^ {3{entry[3] & ctrl[0]}};
		if (onCursor && ctrl[7])
			c = ~c;
		return c;
	endfunction

	task automatic checkQuiet(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge PIXELCLK);
			assert (rgb == 3'b000) else reportMismatch("rgb after reset", 0, rgb);
			assert (!hSync) else reportMismatch("hSync after reset", 0, hSync);
			assert (!vSync) else reportMismatch("vSync after reset", 0, vSync);
		end
	endtask

	task automatic waitVSyncRise();
		logic last;
		logic rose;
		int cycles;
		last = vSync;
		cycles = 0;
		do begin
			@(negedge PIXELCLK);
			cycles++;
			if (cycles > WaitLimit)
				failRun("Timeout while waiting for a rising edge on vSync");
			rose = vSync && !last;
			last = vSync;
		end while (!rose);
	endtask

	// Sample 0 is the first pixel of line 34, where vSync rose
	task automatic checkFrame(input int frame);
		int line;
		int slot;
		int pix;
		int ahead;
		int aheadLine;
		int aheadSlot;
		int expAdr;
		colour expRgb;
		logic expH;
		logic expV;
		for (int i = 0; i < FrameCycles; i++) begin
			if (i > 0)
				@(negedge PIXELCLK);
			line = (`V_SYNC_START + i / LineCycles) % `V_TOTAL_LINES;
			slot = (i % LineCycles) / `CHAR_PIXELS;
			pix = i % `CHAR_PIXELS;
			expRgb = expectedPixel(line, slot, pix);
			expH = slot >= `H_SYNC_START && slot < `H_SYNC_START + `H_SYNC_CHARS;
			expV = line >= `V_SYNC_START && line < `V_SYNC_START + `V_SYNC_LINES;
			assert (rgb == expRgb) else reportMismatch($sformatf(
				"frame %0d rgb at line %0d slot %0d pixel %0d", frame, line, slot, pix),
				expRgb, rgb);
			assert (hSync == expH) else reportMismatch($sformatf(
				"frame %0d hSync at line %0d slot %0d", frame, line, slot), expH, hSync);
			assert (vSync == expV) else reportMismatch($sformatf(
				"frame %0d vSync at line %0d slot %0d", frame, line, slot), expV, vSync);
			// By mid-slot the producer sits one slot beyond a full buffer
			if (pix == 4) begin
				ahead = i / `CHAR_PIXELS + `FIFO_DEPTH + 1;
				aheadLine = (`V_SYNC_START + ahead / `H_TOTAL_CHARS) % `V_TOTAL_LINES;
				aheadSlot = ahead % `H_TOTAL_CHARS;
				if (aheadLine < `V_SYNC_START) begin
					expAdr = slotAddress(aheadLine, aheadSlot);
					assert (framestoreAdr == expAdr) else reportMismatch($sformatf(
						"frame %0d framestoreAdr at line %0d slot %0d", frame,
						aheadLine, aheadSlot), expAdr, framestoreAdr);
				end
			end
		end
	endtask

	initial begin
		seed = 32'hd2574fa0;
		nRESET = 1'b0;
		cpuWrite = '0;
		repeat (5) @(posedge PIXELCLK);
		#10;
		nRESET = 1'b1;
		// Still in the first line of output and before any hSync
		checkQuiet(100);
		for (int f = 0; f < 4; f++) begin
			waitVSyncRise();
			fork
				programRegisters(f);
				checkFrame(f);
			join
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

/* src/displayControl.sv */
`timescale 1ns/1ps

module displayControl (
	input logic PIXELCLK,
	input logic nRESET,
	input videoPkg::regWrite cpuWrite,
	input videoPkg::charData vData,
	output videoPkg::frameAdr framestoreAdr,
	output videoPkg::colour rgb,
	output logic hSync,
	output logic vSync
);

	import videoPkg::*;

	// Producer to buffer
	logic push;
	charItem pushItem;
	logic creditReturn;

	// Buffer to consumer
	logic pop;
	charItem popItem;
	logic empty;

	crtcAddress crtc (
		.PIXELCLK(PIXELCLK),
		.nRESET(nRESET),
		.cpuWrite(cpuWrite),
		.vData(vData),
		.framestoreAdr(framestoreAdr),
		.creditReturn(creditReturn),
		.push(push),
		.pushItem(pushItem)
	);

	charBuffer buffer (
		.PIXELCLK(PIXELCLK),
		.nRESET(nRESET),
		.push(push),
		.pushItem(pushItem),
		.pop(pop),
		.popItem(popItem),
		.empty(empty),
		.creditReturn(creditReturn)
	);

	videoUla ula (
		.PIXELCLK(PIXELCLK),
		.nRESET(nRESET),
		.cpuWrite(cpuWrite),
		.popItem(popItem),
		.empty(empty),
		.pop(pop),
		.rgb(rgb),
		.hSync(hSync),
		.vSync(vSync)
	);

endmodule

/* src/videoUla.sv */
`timescale 1ns/1ps
`include "videoDefs_defs.svh"

module videoUla (
	input logic PIXELCLK,
	input logic nRESET,
	input videoPkg::regWrite cpuWrite,
	input videoPkg::charItem popItem,
	input logic empty,
	output logic pop,
	output videoPkg::colour rgb,
	output logic hSync,
	output logic vSync
);

	import videoPkg::*;

	// Raster counters
	logic running;
	logic [2:0] pixelCnt;
	logic [3:0] slotCnt;
	logic [5:0] lineCnt;
	logic lastPixel;
	logic lastSlot;
	logic lastLine;

	// Control and palette
	ulaReg regTarget;
	logic ulaWrite;
	logic cursorEnable;
	logic flashEnable;
	paletteEntry palette [16];

	// Pixel stage
	charData shifter;
	charItem curItem;
	logic pixValid;
	logic pixHSync;
	logic pixVSync;
	paletteEntry entry;
	logic visible;
	colour baseColour;
	colour pixColour;

	assign lastPixel = pixelCnt == 3'(`CHAR_PIXELS - 1);
	assign lastSlot = slotCnt == 4'(`H_TOTAL_CHARS - 1);
	assign lastLine = lineCnt == 6'(`V_TOTAL_LINES - 1);

	// One item per slot, taken at its first pixel
	assign pop = running && pixelCnt == 3'd0;

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			running <= 1'b0;
			pixelCnt <= '0;
			slotCnt <= '0;
			lineCnt <= '0;
		end else if (!running) begin
			// Hold at the top left until the first item arrives
			running <= !empty;
		end else begin
			pixelCnt <= lastPixel ? '0 : pixelCnt + 3'd1;
			if (lastPixel) begin
				slotCnt <= lastSlot ? '0 : slotCnt + 4'd1;
				if (lastSlot)
					lineCnt <= lastLine ? '0 : lineCnt + 6'd1;
			end
		end
	end

	assign ulaWrite = cpuWrite.valid && cpuWrite.ula;
	assign regTarget = ulaReg'(cpuWrite.a0);

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			cursorEnable <= 1'b0;
			flashEnable <= 1'b0;
		end else if (ulaWrite && regTarget == ctrlReg) begin
			cursorEnable <= cpuWrite.data[7];
			flashEnable <= cpuWrite.data[0];
		end
	end

	// Logical colour in the high nibble, entry in the low one
	always_ff @(posedge PIXELCLK) begin
		if (ulaWrite && regTarget == paletteReg)
			palette[cpuWrite.data[7:4]] <= cpuWrite.data[3:0];
	end

	// Shifter fills with ones, so idle bits select entry 15
	always_ff @(posedge PIXELCLK) begin
		if (pop) begin
			shifter <= popItem.data;
			curItem <= popItem;
		end else begin
			shifter <= {shifter[6:0], 1'b1};
		end
	end

	// Sync and valid follow the shifter by one stage
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			pixValid <= 1'b0;
			pixHSync <= 1'b0;
			pixVSync <= 1'b0;
		end else begin
			pixValid <= running;
			pixHSync <= running
				&& slotCnt >= 4'(`H_SYNC_START)
				&& slotCnt < 4'(`H_SYNC_START + `H_SYNC_CHARS);
			pixVSync <= running
				&& lineCnt >= 6'(`V_SYNC_START)
				&& lineCnt < 6'(`V_SYNC_START + `V_SYNC_LINES);
		end
	end

	always_comb begin
		entry = palette[{shifter[7], shifter[5], shifter[3], shifter[1]}];
		// Scanlines 8 and up are the gap between text rows
		visible = curItem.displayEnable && curItem.rowAddress < 5'd8;
		baseColour = visible ? entry[2:0] ^ {3{entry[3] & flashEnable}} : 3'b000;
		pixColour = baseColour ^ {3{curItem.cursor & cursorEnable}};
	end

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			rgb <= '0;
			hSync <= 1'b0;
			vSync <= 1'b0;
		end else begin
			rgb <= pixValid ? pixColour : 3'b000;
			hSync <= pixHSync;
			vSync <= pixVSync;
		end
	end

	// Producer must stay ahead once the raster runs
	assert property (@(posedge PIXELCLK) disable iff (!nRESET) pop |-> !empty)
		else $error("videoUla: character buffer ran dry");

endmodule

/* src/charBuffer.sv */
`timescale 1ns/1ps
`include "videoDefs_defs.svh"

module charBuffer (
	input logic PIXELCLK,
	input logic nRESET,
	input logic push,
	input videoPkg::charItem pushItem,
	input logic pop,
	output videoPkg::charItem popItem,
	output logic empty,
	output logic creditReturn
);

	import videoPkg::*;

	localparam int PtrBits = $clog2(`FIFO_DEPTH);

	charItem mem [`FIFO_DEPTH];
	logic [PtrBits-1:0] wrPtr;
	logic [PtrBits-1:0] rdPtr;
	logic [PtrBits:0] count;
	logic full;

	assign empty = count == '0;
	assign full = count == (PtrBits + 1)'(`FIFO_DEPTH);

	// Head item is visible before the pop
	assign popItem = mem[rdPtr];

	always_ff @(posedge PIXELCLK) begin
		if (push)
			mem[wrPtr] <= pushItem;
	end

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			creditReturn <= 1'b0;
		end else begin
			if (push)
				wrPtr <= wrPtr == PtrBits'(`FIFO_DEPTH - 1) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr == PtrBits'(`FIFO_DEPTH - 1) ? '0 : rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// Freed slot goes back to the producer
			creditReturn <= pop;
		end
	end

	assert property (@(posedge PIXELCLK) disable iff (!nRESET) push |-> !full)
		else $error("charBuffer: push into full buffer");

	assert property (@(posedge PIXELCLK) disable iff (!nRESET) pop |-> !empty)
		else $error("charBuffer: pop from empty buffer");

endmodule

/* src/crtcAddress.sv */
`timescale 1ns/1ps
`include "videoDefs_defs.svh"

module crtcAddress (
	input logic PIXELCLK,
	input logic nRESET,
	input videoPkg::regWrite cpuWrite,
	input videoPkg::charData vData,
	output videoPkg::frameAdr framestoreAdr,
	input logic creditReturn,
	output logic push,
	output videoPkg::charItem pushItem
);

	import videoPkg::*;

	// CRTC register file
	logic [4:0] regSel;
	logic [7:0] horzDisplay;
	logic [6:0] vertDisplay;
	rowAdr maxScanline;
	rowAdr cursorStartRow;
	rowAdr cursorEndRow;
	frameAdr startAdr;
	frameAdr cursorAdr;

	// Raster walk position
	logic [3:0] colCnt;
	logic [5:0] lineCnt;
	logic [6:0] rowCnt;
	rowAdr rowAddress;
	frameAdr lineStartAdr;

	logic [2:0] credits;
	logic crtcWrite;
	logic fire;
	logic lastCol;
	logic lastLine;
	logic lastScan;
	logic displayEnable;
	logic atCursor;

	assign crtcWrite = cpuWrite.valid && !cpuWrite.ula;

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			regSel <= '0;
			horzDisplay <= '0;
			vertDisplay <= '0;
			maxScanline <= '0;
			cursorStartRow <= '0;
			cursorEndRow <= '0;
			startAdr <= '0;
			cursorAdr <= '0;
		end else if (crtcWrite) begin
			if (!cpuWrite.a0) begin
				regSel <= cpuWrite.data[4:0];
			end else begin
				case (regSel)
					5'd1: horzDisplay <= cpuWrite.data;
					5'd6: vertDisplay <= cpuWrite.data[6:0];
					5'd9: maxScanline <= cpuWrite.data[4:0];
					5'd10: cursorStartRow <= cpuWrite.data[4:0];
					5'd11: cursorEndRow <= cpuWrite.data[4:0];
					5'd12: startAdr[13:8] <= cpuWrite.data[5:0];
					5'd13: startAdr[7:0] <= cpuWrite.data;
					5'd14: cursorAdr[13:8] <= cpuWrite.data[5:0];
					5'd15: cursorAdr[7:0] <= cpuWrite.data;
					default: ;
				endcase
			end
		end
	end

	// Address of the current slot wraps at 16K
	assign framestoreAdr = lineStartAdr + frameAdr'(colCnt);

	assign displayEnable = 8'(colCnt) < horzDisplay
		&& rowCnt < vertDisplay
		&& lineCnt < 6'(`V_SYNC_START);

	assign atCursor = framestoreAdr == cursorAdr
		&& rowAddress >= cursorStartRow
		&& rowAddress <= cursorEndRow
		&& displayEnable;

	// A slot is emitted whenever the buffer has room
	assign fire = credits != 3'd0;

	assign lastCol = colCnt == 4'(`H_TOTAL_CHARS - 1);
	assign lastLine = lineCnt == 6'(`V_TOTAL_LINES - 1);
	assign lastScan = rowAddress == maxScanline;

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			colCnt <= '0;
			lineCnt <= '0;
			rowCnt <= '0;
			rowAddress <= '0;
			lineStartAdr <= '0;
		end else if (fire) begin
			if (!lastCol) begin
				colCnt <= colCnt + 4'd1;
			end else begin
				colCnt <= '0;
				if (lastLine) begin
					// New frame restarts from the start address
					lineCnt <= '0;
					rowCnt <= '0;
					rowAddress <= '0;
					lineStartAdr <= startAdr;
				end else begin
					lineCnt <= lineCnt + 6'd1;
					if (lastScan) begin
						rowAddress <= '0;
						rowCnt <= rowCnt + 7'd1;
						lineStartAdr <= lineStartAdr + frameAdr'(horzDisplay);
					end else begin
						rowAddress <= rowAddress + 5'd1;
					end
				end
			end
		end
	end

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			push <= 1'b0;
			credits <= 3'(`FIFO_DEPTH);
		end else begin
			push <= fire;
			case ({fire, creditReturn})
				2'b10: credits <= credits - 3'd1;
				2'b01: credits <= credits + 3'd1;
				default: credits <= credits;
			endcase
		end
	end

	// Item is built from the byte read this cycle
	always_ff @(posedge PIXELCLK) begin
		if (fire) begin
			pushItem.data <= vData;
			pushItem.rowAddress <= rowAddress;
			pushItem.displayEnable <= displayEnable;
			pushItem.cursor <= atCursor;
			pushItem.spare <= 1'b0;
		end
	end

	// Buffer must never return more credits than it was given
	assert property (@(posedge PIXELCLK) disable iff (!nRESET)
		credits <= 3'(`FIFO_DEPTH))
		else $error("crtcAddress: credit count above buffer depth");

endmodule

/* src/videoPkg.sv */
package videoPkg;

	// Framestore address and byte
	typedef logic [13:0] frameAdr;
	typedef logic [7:0] charData;

	// Scanline inside a character row
	typedef logic [4:0] rowAdr;

	// One bit per gun with red on top
	typedef logic [2:0] colour;

	// Flash bit above three colour bits
	typedef logic [3:0] paletteEntry;

	// One character slot as handed from CRTC to ULA
	typedef struct packed {
		charData data;
		rowAdr rowAddress;
		logic displayEnable;
		logic cursor;
		logic spare;
	} charItem;

	// Write-only processor port shared by CRTC and ULA
	typedef struct packed {
		logic valid;
		logic ula;
		logic a0;
		logic [7:0] data;
	} regWrite;

	// ULA register picked by a0
	typedef enum logic {
		ctrlReg = 1'b0,
		paletteReg = 1'b1
	} ulaReg;

endpackage

/* src/videoDefs_defs.svh */
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// Pixels shifted out per character slot
`define CHAR_PIXELS 8

// Character slots in one scanline, blank ones included
`define H_TOTAL_CHARS 16

// Line sync covers slots 13 and 14
`define H_SYNC_START 13
`define H_SYNC_CHARS 2

// Scanlines in one frame
`define V_TOTAL_LINES 40

// Frame sync covers lines 34 and 35
`define V_SYNC_START 34
`define V_SYNC_LINES 2

// Character items held between the CRTC and the ULA.
// The producer starts with this many credits.
`define FIFO_DEPTH 4

`endif
